/* common/alu_config.svh */
/*
 * Execute stage constants: datapath width, shift amount width
 * and the result returned for undefined opcodes
 */
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

`define ALU_WIDTH      16       // Datapath width in bits
`define ALU_SHAMT_W    4        // Shift amount bits taken from rt
`define ALU_BAD_RESULT 16'hDEAD // Returned for opcodes 12 to 15

`endif

/* common/alu_pkg.sv */
/*
 * Execute stage types: opcode enum, adder and shifter modes,
 * flag struct, request and response structs
 */
`include "alu_config.svh"

package alu_pkg;

    // Instruction opcodes, 4 bits wide
    typedef enum logic [3:0] {
        ADD       = 4'd0,
        SUB       = 4'd1,
        XOR       = 4'd2,
        RED       = 4'd3,
        SLL       = 4'd4,
        SRA       = 4'd5,
        ROR       = 4'd6,
        PADDSB    = 4'd7,
        LW        = 4'd8,
        SW        = 4'd9,
        LLB       = 4'd10,
        LHB       = 4'd11,
        OP_RSVD12 = 4'd12,
        OP_RSVD13 = 4'd13,
        OP_RSVD14 = 4'd14,
        OP_RSVD15 = 4'd15
    } alu_op_e;

    typedef enum logic [2:0] {
        ADD_SAT,  // Saturating add
        SUB_SAT,  // Saturating subtract
        RED_SUM,  // Byte reduction
        NIB_SAT,  // Nibble-parallel saturating add
        ADD_WRAP  // Plain sum for address generation
    } adder_mode_e;

    typedef enum logic [1:0] {
        SH_SLL,   // Logical left, zero fill
        SH_SRA,   // Arithmetic right, sign fill
        SH_ROR    // Rotate right
    } shift_mode_e;

    // Also used as the per-flag write mask
    typedef struct packed {
        logic n;
        logic v;
        logic z;
    } alu_flags_t;

    typedef struct packed {
        alu_op_e               op;
        logic [`ALU_WIDTH-1:0] rs;
        logic [`ALU_WIDTH-1:0] rt;
    } alu_req_t;

    typedef struct packed {
        logic [`ALU_WIDTH-1:0] rd;
        alu_flags_t            flags;
    } alu_resp_t;

endpackage

/* alu/adder_multifunc.sv */
/*
 * Multifunction adder: saturating add/subtract on one shared adder,
 * signed byte reduction and nibble-parallel saturating add
 */
`timescale 1ns/1ns
`include "alu_config.svh"

module adder_multifunc (
    input  logic [`ALU_WIDTH-1:0] a,
    input  logic [`ALU_WIDTH-1:0] b,
    input  alu_pkg::adder_mode_e  mode,
    output logic [`ALU_WIDTH-1:0] s,
    output logic                  ovfl
);

    import alu_pkg::*;

    logic                  sub;
    logic [`ALU_WIDTH-1:0] b_eff;
    logic [`ALU_WIDTH-1:0] sum;
    logic                  sum_ovfl;
    logic [`ALU_WIDTH-1:0] sat_sum;
    logic [8:0]            red_rs;
    logic [8:0]            red_rt;
    logic [9:0]            red_total;
    logic [`ALU_WIDTH-1:0] red_ext;
    logic [`ALU_WIDTH-1:0] nib_sum;

    // Shared adder, subtract as a + ~b + 1
    assign sub   = (mode == SUB_SAT);
    assign b_eff = sub ? ~b : b;
    assign sum   = a + b_eff + {{(`ALU_WIDTH-1){1'b0}}, sub};

    // Operands agree in sign but the sum does not
    assign sum_ovfl = (a[`ALU_WIDTH-1] == b_eff[`ALU_WIDTH-1])
                   && (sum[`ALU_WIDTH-1] != a[`ALU_WIDTH-1]);

    always_comb begin
        if (!sum_ovfl)
            sat_sum = sum;
        else if (a[`ALU_WIDTH-1])
            sat_sum = {1'b1, {(`ALU_WIDTH-1){1'b0}}}; // Clamp negative
        else
            sat_sum = {1'b0, {(`ALU_WIDTH-1){1'b1}}}; // Clamp positive
    end

    // Reduction tree over the four signed bytes
    assign red_rs    = {a[15], a[15:8]} + {a[7], a[7:0]};
    assign red_rt    = {b[15], b[15:8]} + {b[7], b[7:0]};
    assign red_total = {red_rs[8], red_rs} + {red_rt[8], red_rt};
    assign red_ext   = {{(`ALU_WIDTH-10){red_total[9]}}, red_total};

    // Four independent 4-bit lanes, each clamped to -8..7
    for (genvar i = 0; i < 4; i++) begin : g_nib
        logic [4:0] lane;

        assign lane = {a[4*i+3], a[4*i +: 4]} + {b[4*i+3], b[4*i +: 4]};
        assign nib_sum[4*i +: 4] = (lane[4] != lane[3]) ? (lane[4] ? 4'h8 : 4'h7)
                                                        : lane[3:0];
    end

    always_comb begin
        case (mode)
            ADD_SAT, SUB_SAT: begin
                s    = sat_sum;
                ovfl = sum_ovfl;
            end
            RED_SUM: begin
                s    = red_ext;
                ovfl = 1'b0;
            end
            NIB_SAT: begin
                s    = nib_sum;
                ovfl = 1'b0;     // Lane clamps do not raise V
            end
            default: begin
                s    = sum;      // ADD_WRAP, address sum
                ovfl = 1'b0;
            end
        endcase
    end

endmodule

/* alu/shifter.sv */
/*
 * Logarithmic barrel shifter: logical left, arithmetic right, rotate right
 */
`timescale 1ns/1ns
`include "alu_config.svh"

module shifter (
    input  logic [`ALU_WIDTH-1:0]   shift_in,
    input  logic [`ALU_SHAMT_W-1:0] shamt,
    input  alu_pkg::shift_mode_e    mode,
    output logic [`ALU_WIDTH-1:0]   shift_out
);

    import alu_pkg::*;

    logic [`ALU_WIDTH-1:0] stage [0:`ALU_SHAMT_W];

    assign stage[0] = shift_in;

    // Stage i moves by 2**i when shamt[i] is set
    for (genvar i = 0; i < `ALU_SHAMT_W; i++) begin : g_stage
        localparam int AMT = 1 << i;

        logic [`ALU_WIDTH-1:0] moved;

        always_comb begin
            case (mode)
                SH_SRA:  moved = $unsigned($signed(stage[i]) >>> AMT); // Sign fill
                SH_ROR:  moved = (stage[i] >> AMT) | (stage[i] << (`ALU_WIDTH - AMT));
                default: moved = stage[i] << AMT;                      // Zero fill
            endcase
        end

        assign stage[i+1] = shamt[i] ? moved : stage[i];
    end

    assign shift_out = stage[`ALU_SHAMT_W];

endmodule

/* alu/alu.sv */
/*
 * 16-bit ALU: opcode decode, adder and shifter select, result mux,
 * flag values and per-flag write mask
 */
`timescale 1ns/1ns
`include "alu_config.svh"

module alu (
    input  alu_pkg::alu_op_e      op,
    input  logic [`ALU_WIDTH-1:0] rs,
    input  logic [`ALU_WIDTH-1:0] rt,
    output logic [`ALU_WIDTH-1:0] rd,
    output alu_pkg::alu_flags_t   flags,
    output alu_pkg::alu_flags_t   flag_we
);

    import alu_pkg::*;

    adder_mode_e           adder_mode;
    shift_mode_e           shift_mode;
    logic [`ALU_WIDTH-1:0] adder_out;
    logic                  adder_ovfl;
    logic [`ALU_WIDTH-1:0] shift_out;
    logic [`ALU_WIDTH-1:0] xor_out;
    logic [`ALU_WIDTH-1:0] llb_out;
    logic [`ALU_WIDTH-1:0] lhb_out;

    adder_multifunc adder_inst (
        .a    (rs),
        .b    (rt),
        .mode (adder_mode),
        .s    (adder_out),
        .ovfl (adder_ovfl)
    );

    shifter shifter_inst (
        .shift_in  (rs),
        .shamt     (rt[`ALU_SHAMT_W-1:0]),
        .mode      (shift_mode),
        .shift_out (shift_out)
    );

    assign xor_out = rs ^ rt;
    assign llb_out = {rs[15:8], rt[7:0]}; // Replace low byte
    assign lhb_out = {rt[7:0], rs[7:0]};  // Replace high byte

    always_comb begin
        case (op)
            ADD:     adder_mode = ADD_SAT;
            SUB:     adder_mode = SUB_SAT;
            RED:     adder_mode = RED_SUM;
            PADDSB:  adder_mode = NIB_SAT;
            default: adder_mode = ADD_WRAP; // LW, SW and unused
        endcase
    end

    always_comb begin
        case (op)
            SRA:     shift_mode = SH_SRA;
            ROR:     shift_mode = SH_ROR;
            default: shift_mode = SH_SLL;
        endcase
    end

    always_comb begin
        case (op)
            ADD, SUB, RED, PADDSB, LW, SW: rd = adder_out;
            XOR:                           rd = xor_out;
            SLL, SRA, ROR:                 rd = shift_out;
            LLB:                           rd = llb_out;
            LHB:                           rd = lhb_out;
            default:                       rd = `ALU_BAD_RESULT;
        endcase
    end

    // Flag values, written only where the mask allows
    assign flags.n = rd[`ALU_WIDTH-1];
    assign flags.v = adder_ovfl;
    assign flags.z = (rd == '0);

    always_comb begin
        flag_we = '0;
        case (op)
            ADD, SUB: begin
                flag_we.n = 1'b1;
                flag_we.v = 1'b1;
                flag_we.z = 1'b1;
            end
            XOR, SLL, SRA, ROR: flag_we.z = 1'b1; // Z only
            default: ;
        endcase
    end

    // Undefined opcodes must never touch the status register
    always_comb begin
        if (op inside {OP_RSVD12, OP_RSVD13, OP_RSVD14, OP_RSVD15}) begin
            assert (flag_we == '0)
                else $error("alu: flag write mask set for undefined opcode %0d", op);
        end
    end

endmodule

/* verilog/flag_register.sv */
/*
 * Processor status register holding N, V and Z with per-flag write mask
 */
`timescale 1ns/1ns

module flag_register (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we,
    input  alu_pkg::alu_flags_t flags,
    input  alu_pkg::alu_flags_t flag_we,
    output alu_pkg::alu_flags_t status
);

    import alu_pkg::*;

    logic [2:0] hold_mask;

    assign hold_mask = ~flag_we; // Bits that must keep their value

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status <= '0;
        end else if (we) begin
            if (flag_we.n) status.n <= flags.n;
            if (flag_we.v) status.v <= flags.v;
            if (flag_we.z) status.z <= flags.z;
        end
    end

    // Masked-off flags survive a write
    assert property (@(posedge clk) disable iff (!rst_n)
        we |=> ((status ^ $past(status)) & $past(hold_mask)) == 3'b000)
        else $error("flag_register: masked flag changed on write");

endmodule

/* verilog/execute_unit.sv */
/*
 * Execute stage top level: ALU, registered result with valid strobe
 * and the processor status register
 */
`timescale 1ns/1ns
`include "alu_config.svh"

module execute_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  alu_pkg::alu_req_t   req,
    output logic                resp_valid,
    output alu_pkg::alu_resp_t  resp,
    output alu_pkg::alu_flags_t status
);

    import alu_pkg::*;

    logic [`ALU_WIDTH-1:0] alu_rd;
    alu_flags_t            alu_flags;
    alu_flags_t            alu_flag_we;

    alu alu_inst (
        .op      (req.op),
        .rs      (req.rs),
        .rt      (req.rt),
        .rd      (alu_rd),
        .flags   (alu_flags),
        .flag_we (alu_flag_we)
    );

    // Status loads on the same edge as the result register
    flag_register flag_register_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (req_valid),
        .flags   (alu_flags),
        .flag_we (alu_flag_we),
        .status  (status)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
            resp       <= '0;
        end else begin
            resp_valid <= req_valid; // One cycle of latency
            if (req_valid) begin
                resp.rd    <= alu_rd;
                resp.flags <= alu_flags;
            end
        end
    end

    // No stale strobe may leak out of reset
    assert property (@(posedge clk) !rst_n |=> !resp_valid)
        else $error("execute_unit: resp_valid high right after reset");

endmodule

/* sim/alu_model.svh */
/*
 * Testbench reference model: expected result, saturation,
 * flag values and flag write mask for every opcode
 */
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

function automatic int clamp_int(int val, int lo, int hi);
    if (val > hi)
        return hi;
    if (val < lo)
        return lo;
    return val;
endfunction

// Signed byte or nibble of a word, sign extended
function automatic int signed_byte(logic [15:0] w, int idx);
    logic [7:0] bt;
    bt = w[8*idx +: 8];
    return $signed(bt);
endfunction

function automatic int signed_nibble(logic [15:0] w, int idx);
    logic [3:0] nb;
    nb = w[4*idx +: 4];
    return $signed(nb);
endfunction

function automatic logic [15:0] model_rd(alu_op_e op, logic [15:0] rs, logic [15:0] rt);
    int          a;
    int          b;
    int          acc;
    int          i;
    logic [31:0] twice;
    logic [15:0] res;
    a   = $signed(rs);
    b   = $signed(rt);
    res = `ALU_BAD_RESULT;
    case (op)
        ADD: begin
            acc = clamp_int(a + b, -32768, 32767);
            res = acc[15:0];
        end
        SUB: begin
            acc = clamp_int(a - b, -32768, 32767);
            res = acc[15:0];
        end
        XOR: res = rs ^ rt;
        RED: begin
            acc = signed_byte(rs, 1) + signed_byte(rs, 0)
                + signed_byte(rt, 1) + signed_byte(rt, 0);
            res = acc[15:0];
        end
        SLL: res = rs << rt[3:0];
        SRA: begin
            acc = a >>> rt[3:0]; // a is already sign extended
            res = acc[15:0];
        end
        ROR: begin
            twice = {rs, rs};
            twice = twice >> rt[3:0];
            res   = twice[15:0];
        end
        PADDSB: begin
            for (i = 0; i < 4; i++) begin
                acc = clamp_int(signed_nibble(rs, i) + signed_nibble(rt, i), -8, 7);
                res[4*i +: 4] = acc[3:0];
            end
        end
        LW, SW: res = rs + rt;   // Address sum wraps
        LLB:    res = {rs[15:8], rt[7:0]};
        LHB:    res = {rt[7:0], rs[7:0]};
        default: res = `ALU_BAD_RESULT;
    endcase
    return res;
endfunction

function automatic logic model_sat(alu_op_e op, logic [15:0] rs, logic [15:0] rt);
    int full;
    case (op)
        ADD:     full = $signed(rs) + $signed(rt);
        SUB:     full = $signed(rs) - $signed(rt);
        default: return 1'b0;
    endcase
    return (full > 32767) || (full < -32768);
endfunction

function automatic alu_flags_t model_flags(alu_op_e op, logic [15:0] rs, logic [15:0] rt);
    alu_flags_t  f;
    logic [15:0] r;
    r   = model_rd(op, rs, rt);
    f.n = r[15];
    f.v = model_sat(op, rs, rt);
    f.z = (r == 16'h0000);
    return f;
endfunction

function automatic alu_flags_t model_mask(alu_op_e op);
    alu_flags_t m;
    m = '0;
    case (op)
        ADD, SUB: begin
            m.n = 1'b1;
            m.v = 1'b1;
            m.z = 1'b1;
        end
        XOR, SLL, SRA, ROR: m.z = 1'b1;
        default: ;
    endcase
    return m;
endfunction

`endif

/* sim/tb_execute_unit.sv */
/*
 * Testbench for the execute stage: clock, reset, directed and random
 * requests, response and status compare, timeout and summary
 */
`timescale 1ns/1ns
`include "alu_config.svh"

module tb_execute_unit;

    import alu_pkg::*;

    `include "alu_model.svh"

    localparam int N_ARITH        = 40;
    localparam int N_LOGIC        = 58;
    localparam int N_FLAGS        = 17;
    localparam int N_RAND         = 400;
    localparam int TOTAL_REQS     = N_ARITH + N_LOGIC + N_FLAGS + N_RAND;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_REQS + 100;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    alu_req_t   req;
    logic       resp_valid;
    alu_resp_t  resp;
    alu_flags_t status;

    alu_resp_t  exp_resp_q [$];
    alu_flags_t exp_status_q [$];
    alu_resp_t  exp_resp;
    alu_flags_t exp_status;
    alu_flags_t shadow;      // Expected status register
    integer     seed;
    int         cycle_count;
    int         resp_count;
    int         errors;
    int         checks;
    int         tests_run;
    int         tests_failed;
    int         test_err_start;
    string      test_name;

    execute_unit execute_unit_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .resp_valid (resp_valid),
        .resp       (resp),
        .status     (status)
    );

    always #10 clk = ~clk;

    function automatic logic [15:0] rand16();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic logic [15:0] rt_with_shamt(int amt);
        logic [15:0] r;
        r      = rand16();
        r[3:0] = amt[3:0]; // Upper bits random and ignored
        return r;
    endfunction

    task automatic check_resp(input alu_resp_t exp, input alu_resp_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s resp: expected rd=%h nvz=%b, actual rd=%h nvz=%b",
                     test_name, exp.rd, exp.flags, act.rd, act.flags);
        end
    endtask

    task automatic check_status(input alu_flags_t exp, input alu_flags_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s status: expected nvz=%b, actual nvz=%b", test_name, exp, act);
        end
    endtask

    // Drives one request per call
    task automatic send_req(input alu_op_e op, input logic [15:0] rs, input logic [15:0] rt);
        alu_resp_t  e;
        alu_flags_t m;
        @(posedge clk);
        #2;
        req_valid = 1'b1;
        req.op    = op;
        req.rs    = rs;
        req.rt    = rt;
        e.rd      = model_rd(op, rs, rt);
        e.flags   = model_flags(op, rs, rt);
        m         = model_mask(op);
        shadow    = (shadow & ~m) | (e.flags & m);
        exp_resp_q.push_back(e);
        exp_status_q.push_back(shadow);
    endtask

    task automatic drain_responses();
        int waited;
        waited = 0;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
        while (exp_resp_q.size() != 0 && waited < 8) begin
            @(posedge clk);
            waited++;
        end
        if (exp_resp_q.size() != 0) begin
            errors++;
            $display("Missing response: %0d requests in test %s got no resp_valid",
                     exp_resp_q.size(), test_name);
            exp_resp_q.delete();
            exp_status_q.delete();
        end
    endtask

    task automatic begin_test(input string name);
        test_name      = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_err_start)
            tests_failed++;
        $display("Test %-10s finished with %0d errors", test_name, errors - test_err_start);
    endtask

    task automatic arith_test();
        int i;
        begin_test("arith");
        send_req(ADD, 16'h7000, 16'h2000);    // Clamps to 7FFF
        send_req(ADD, 16'h9000, 16'hA000);    // Clamps to 8000
        send_req(SUB, 16'h7FF0, 16'hFF00);
        send_req(SUB, 16'h8010, 16'h0100);
        send_req(ADD, 16'h1234, 16'h0111);
        send_req(SUB, 16'h0005, 16'h0005);    // Zero result
        send_req(LW, 16'h7FFF, 16'h0001);     // Wraps without clamping
        send_req(SW, 16'hFFFF, 16'h0002);
        send_req(RED, 16'h7F7F, 16'h7F7F);
        send_req(RED, 16'h8080, 16'h8080);
        send_req(PADDSB, 16'h7F80, 16'h7181); // Lanes clamp both ways
        for (i = 0; i < N_ARITH - 11; i++)
            send_req(i[0] ? PADDSB : RED, rand16(), rand16());
        drain_responses();
        end_test();
    endtask

    task automatic logic_test();
        int amt;
        begin_test("logic");
        send_req(XOR, 16'hA5A5, 16'h5A5A);
        send_req(XOR, 16'h1234, 16'h1234);
        send_req(XOR, rand16(), rand16());
        send_req(XOR, 16'hFFFF, 16'h0000);
        for (amt = 0; amt < 16; amt++) begin
            send_req(SLL, rand16(), rt_with_shamt(amt));
            send_req(SRA, rand16(), rt_with_shamt(amt));
            send_req(ROR, rand16(), rt_with_shamt(amt));
        end
        send_req(SLL, 16'h8000, 16'h0001);    // Shifted out to zero
        send_req(SRA, 16'h0001, 16'h0001);
        send_req(LLB, 16'hAB12, 16'h34CD);
        send_req(LLB, rand16(), rand16());
        send_req(LHB, 16'hAB12, 16'h34CD);
        send_req(LHB, rand16(), rand16());
        drain_responses();
        end_test();
    endtask

    task automatic flag_test();
        begin_test("flags");
        send_req(ADD, 16'h8000, 16'h8000);    // N and V set
        send_req(XOR, 16'h00FF, 16'h00FF);    // Z set while N and V hold
        send_req(SLL, 16'h0001, 16'h0004);
        send_req(SRA, 16'h8000, 16'h000F);
        send_req(ROR, 16'h0001, 16'h0001);
        send_req(LLB, 16'h0000, 16'h0000);
        send_req(LHB, 16'h8000, 16'h0080);
        send_req(RED, 16'h0000, 16'h0000);
        send_req(PADDSB, 16'h7777, 16'h1111);
        send_req(LW, 16'h8000, 16'h8000);
        send_req(SW, 16'h0000, 16'h0000);
        send_req(OP_RSVD12, 16'h0000, 16'h0000);
        send_req(OP_RSVD13, 16'h7FFF, 16'h0001);
        send_req(OP_RSVD14, 16'h8000, 16'h8000);
        send_req(OP_RSVD15, 16'hFFFF, 16'hFFFF);
        send_req(SUB, 16'h0003, 16'h0001);    // Clears N V Z
        send_req(OP_RSVD13, 16'h0000, 16'h0000);
        drain_responses();
        end_test();
    endtask

    task automatic throughput_test();
        int          i;
        int          start;
        logic [31:0] r;
        begin_test("throughput");
        start = resp_count;
        for (i = 0; i < N_RAND; i++) begin
            r = $random(seed);
            send_req(alu_op_e'(r[3:0]), rand16(), rand16());
        end
        drain_responses();
        if (resp_count - start != N_RAND) begin
            errors++;
            $display("FAIL %s response count: expected %0d, actual %0d",
                     test_name, N_RAND, resp_count - start);
        end
        end_test();
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && resp_valid) begin
            resp_count++;
            if (exp_resp_q.size() == 0) begin
                errors++;
                $display("Unexpected response: resp_valid high with no pending request in %s",
                         test_name);
            end else begin
                exp_resp   = exp_resp_q.pop_front();
                exp_status = exp_status_q.pop_front();
                check_resp(exp_resp, resp);
                check_status(exp_status, status);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: run went past %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req            = '0;
        seed           = 32'h935f;
        shadow         = '0;
        cycle_count    = 0;
        resp_count     = 0;
        errors         = 0;
        checks         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_err_start = 0;
        test_name      = "init";
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        begin_test("reset");
        @(negedge clk);
        checks++;
        if (resp_valid !== 1'b0) begin
            errors++;
            $display("FAIL %s resp_valid: expected 0, actual %b", test_name, resp_valid);
        end
        check_resp('0, resp);
        check_status('0, status);
        end_test();

        arith_test();
        logic_test();
        flag_test();
        throughput_test();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d responses",
                 tests_run, tests_failed, checks, errors, resp_count);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+common
+incdir+sim
common/alu_pkg.sv
alu/adder_multifunc.sv
alu/shifter.sv
alu/alu.sv
verilog/flag_register.sv
verilog/execute_unit.sv
sim/tb_execute_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_execute_unit -f flist.f -Mdir obj_dir > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/Vtb_execute_unit > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST FAILED" "$SIM_LOG"; then
    echo "Simulation reported a failure, see $SIM_LOG"
    exit 1
fi

echo "Simulation passed"
exit 0
